//--- build.f
hw/dsp_pkg.sv
hw/lane_history.sv
hw/dsp_config_regs.sv
hw/ffe_filter.sv
hw/slicer.sv
hw/mlsd_checker.sv
hw/dsp_backend.sv
dv/dsp_backend_chk.sv
dv/dsp_backend_tb.sv

//--- dv/dsp_backend_chk.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_backend_chk (
	input  logic clk,
	input  logic rstb,

	input  logic signed [dsp_pkg::est_out_bits-1:0] est_i [dsp_pkg::lanes-1:0],
	input  logic        [dsp_pkg::lanes-1:0]        sliced_i,
	input  logic        [dsp_pkg::lanes-1:0]        checked_i,
	input  logic signed [dsp_pkg::thresh_bits-1:0]  thresh_i
);

	localparam logic [dsp_pkg::est_out_bits-1:0] est_floor =
		{1'b1, {(dsp_pkg::est_out_bits-1){1'b0}}};

	logic [dsp_pkg::lanes-1:0] cmp;
	logic                      est_zero;
	logic                      est_min;

	always_comb begin
		est_zero = 1'b1;
		est_min  = 1'b0;
		for (int l = 0; l < dsp_pkg::lanes; l++) begin
			cmp[l] = (est_i[l] >= thresh_i);   // slicer rule.
			if (est_i[l] != '0) begin
				est_zero = 1'b0;
			end
			if (est_i[l] == est_floor) begin
				est_min = 1'b1;
			end
		end
	end

	// ############################################################
	reset_clears: assert property (@(posedge clk)
		!rstb |-> (est_zero && sliced_i == '0 && checked_i == '0))
		else $error("outputs not cleared while reset is held");

	slice_follows: assert property (@(posedge clk) disable iff (!rstb)
		$past(rstb) |-> sliced_i == $past(cmp))
		else $error("sliced bits differ from the last estimate against the threshold");

	est_in_range: assert property (@(posedge clk) !est_min)
		else $error("estimate reached -512 past the clamp");

endmodule : dsp_backend_chk

bind dsp_backend dsp_backend_chk chk_i (
	.clk       (clk),
	.rstb      (rstb),
	.est_i     (estimated_bits_o),
	.sliced_i  (sliced_bits_o),
	.checked_i (checked_bits_o),
	.thresh_i  (thresh)
);

`default_nettype wire

//--- dv/dsp_backend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_backend_tb;

	localparam int num_rows = 17;
	localparam int max_cyc  = 1024;
	localparam int drain    = 6;
	localparam int base     = 4;   // slots for the zero words before the first one.

	typedef struct packed {
		logic        we;
		logic [3:0]  addr;
		logic [15:0] data;
		logic [31:0] word;     // lane 0 in the low byte.
		logic [15:0] n_rand;   // zero means the one fixed word.
		logic        mix;      // random config writes inside the stream.
	} row_t;

	logic clk;
	logic rstb;
	logic signed [dsp_pkg::code_bits-1:0]    codes [dsp_pkg::lanes-1:0];
	logic                                    cfg_we;
	logic [dsp_pkg::cfg_addr_bits-1:0]       cfg_addr;
	dsp_pkg::dsp_cfg_word_u                  cfg_data;
	logic signed [dsp_pkg::est_out_bits-1:0] est [dsp_pkg::lanes-1:0];
	logic [dsp_pkg::lanes-1:0]               sliced;
	logic [dsp_pkg::lanes-1:0]               checked;

	string names [num_rows] = '{"idle_random", "w0_load", "w0_pass", "w1_load", "w1_edge",
		"w0_big", "w2_big", "shift_small", "shift_large", "sat_shift0", "thresh_pos",
		"thresh_neg", "h0_load", "h1_load", "mlsd_stream", "unmapped", "random_mix"};

	row_t rows [num_rows] = '{
		'{1'b0, 4'h0, 16'h0000, 32'h0000_0000, 16'd8,   1'b0},
		'{1'b1, 4'h0, 16'h0001, 32'h7f80_0103, 16'd0,   1'b0},   // w0 = 1.
		'{1'b0, 4'h0, 16'h0000, 32'h10f0_2040, 16'd0,   1'b0},
		'{1'b1, 4'h1, 16'h00ff, 32'h0405_0607, 16'd0,   1'b0},   // w1 = -1.
		'{1'b0, 4'h0, 16'h0000, 32'h1122_3344, 16'd0,   1'b0},
		'{1'b1, 4'h0, 16'h007f, 32'h7f7f_7f7f, 16'd0,   1'b0},
		'{1'b1, 4'h2, 16'h0081, 32'h8080_8080, 16'd0,   1'b0},   // w2 = -127.
		'{1'b1, 4'h3, 16'h2000, 32'h40c0_7f80, 16'd0,   1'b0},
		'{1'b1, 4'h3, 16'ha000, 32'h7f80_7f80, 16'd0,   1'b0},
		'{1'b1, 4'h3, 16'h0000, 32'h0000_0000, 16'd6,   1'b0},
		'{1'b1, 4'h3, 16'h4014, 32'h0000_0000, 16'd6,   1'b0},   // shift 4, thresh 20.
		'{1'b1, 4'h3, 16'h43ec, 32'h0000_0000, 16'd6,   1'b0},   // thresh -20.
		'{1'b1, 4'h4, 16'h0040, 32'h40c0_40c0, 16'd0,   1'b0},
		'{1'b1, 4'h5, 16'h0020, 32'h60a0_20e0, 16'd0,   1'b0},
		'{1'b1, 4'h3, 16'h2000, 32'h0000_0000, 16'd12,  1'b0},
		'{1'b1, 4'h9, 16'h1234, 32'h0102_0304, 16'd0,   1'b0},
		'{1'b1, 4'h0, 16'h0003, 32'h0000_0000, 16'd300, 1'b1}
	};

	// reference model state with one slot per applied word.
	int          code_log [max_cyc][dsp_pkg::lanes];
	int          est_exp  [max_cyc][dsp_pkg::lanes];
	int          slc_exp  [max_cyc][dsp_pkg::lanes];
	int          chk_exp  [max_cyc][dsp_pkg::lanes];
	string       word_tag [max_cyc];
	int          m_w [dsp_pkg::ffe_taps];
	int          m_thr;
	int          m_sh;
	int          m_h0;
	int          m_h1;
	logic [31:0] lfsr;
	int          cyc;

	dsp_backend #(
		.hist_depth (4)
	) UUT (
		.clk              (clk),
		.rstb             (rstb),
		.codes_i          (codes),
		.cfg_we_i         (cfg_we),
		.cfg_addr_i       (cfg_addr),
		.cfg_data_i       (cfg_data),
		.estimated_bits_o (est),
		.sliced_bits_o    (sliced),
		.checked_bits_o   (checked)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ############################################################
	// random source and reference model
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1.
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic int abs_int(input int v);
		return (v < 0) ? -v : v;
	endfunction

	// code at lane offset off of slot k, reaching into the neighbor words.
	function automatic int sym(input int k, input int off);
		if (off < 0) begin
			return code_log[k-1][dsp_pkg::lanes + off];
		end
		if (off >= dsp_pkg::lanes) begin
			return code_log[k+1][off - dsp_pkg::lanes];
		end
		return code_log[k][off];
	endfunction

	function automatic int sign_at(input int k, input int off);
		int b;
		if (off < 0) begin
			b = slc_exp[k-1][dsp_pkg::lanes + off];
		end else if (off >= dsp_pkg::lanes) begin
			b = slc_exp[k+1][off - dsp_pkg::lanes];
		end else begin
			b = slc_exp[k][off];
		end
		return (b != 0) ? 1 : -1;
	endfunction

	function automatic int ffe_model(input int k, input int l);
		int acc;
		acc = m_w[0] * sym(k, l) + m_w[1] * sym(k, l - 1) + m_w[2] * sym(k, l - 2);
		acc = acc >>> m_sh;
		if (acc > 511) begin
			acc = 511;
		end else if (acc < -511) begin
			acc = -511;
		end
		return acc;
	endfunction

	// distance over both codes that symbol l touches, for level d.
	function automatic int seq_err(input int k, input int l, input int d);
		return abs_int(sym(k, l) - m_h0 * d - m_h1 * sign_at(k, l - 1))
			+ abs_int(sym(k, l + 1) - m_h0 * sign_at(k, l + 1) - m_h1 * d);
	endfunction

	task automatic model_write(input logic [3:0] addr, input logic [15:0] data);
		case (addr)
			dsp_pkg::addr_w0: m_w[0] = $signed(data[7:0]);
			dsp_pkg::addr_w1: m_w[1] = $signed(data[7:0]);
			dsp_pkg::addr_w2: m_w[2] = $signed(data[7:0]);
			dsp_pkg::addr_ctrl: begin
				m_thr = $signed(data[9:0]);
				m_sh  = int'(data[15:12]);
			end
			dsp_pkg::addr_h0: m_h0 = $signed(data[7:0]);
			dsp_pkg::addr_h1: m_h1 = $signed(data[7:0]);
			default: begin
			end
		endcase
	endtask

	// ############################################################
	// checks and stimulus
	task automatic check_value(input string test, input int exp_v, input int act_v);
		if (exp_v !== act_v) begin
			$display("mismatch %s expected %0d actual %0d", test, exp_v, act_v);
			$display("Some tests failed");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic check_outputs(input int s);
		for (int l = 0; l < dsp_pkg::lanes; l++) begin
			check_value($sformatf("%s est lane %0d", word_tag[s-1], l),
				est_exp[s-1][l], int'(est[l]));
			check_value($sformatf("%s slice lane %0d", word_tag[s-2], l),
				slc_exp[s-2][l], int'(sliced[l]));
			check_value($sformatf("%s mlsd lane %0d", word_tag[s-4], l),
				chk_exp[s-4][l], int'(checked[l]));
		end
	endtask

	task automatic apply_word(input string tag, input logic [31:0] word, input logic we,
			input logic [3:0] addr, input logic [15:0] data);
		int s;
		s = cyc + base;
		check_outputs(s);
		for (int l = 0; l < dsp_pkg::lanes; l++) begin
			codes[l]       = word[8*l +: 8];
			code_log[s][l] = $signed(word[8*l +: 8]);
		end
		cfg_we      = we;
		cfg_addr    = addr;
		cfg_data    = data;
		word_tag[s] = tag;
		for (int l = 0; l < dsp_pkg::lanes; l++) begin
			est_exp[s][l]   = ffe_model(s, l);
			slc_exp[s-1][l] = (est_exp[s-1][l] >= m_thr) ? 1 : 0;
			chk_exp[s-3][l] = (seq_err(s - 3, l, -sign_at(s - 3, l))
				< seq_err(s - 3, l, sign_at(s - 3, l))) ? 1 : 0;
		end
		if (we) begin
			model_write(addr, data);   // seen by the next word.
		end
		cyc++;
		@(negedge clk);
	endtask

	task automatic run_row(input int r);
		int          n;
		logic [31:0] w;
		logic [31:0] pick;
		logic [31:0] v;
		logic        we;
		logic [3:0]  addr;
		logic [15:0] data;
		n = (rows[r].n_rand == 0) ? 1 : int'(rows[r].n_rand);
		for (int i = 0; i < n; i++) begin
			w = rows[r].word;
			if (rows[r].n_rand != 0) begin
				rand_bits(32, w);
			end
			we   = (i == 0) && rows[r].we;
			addr = rows[r].addr;
			data = rows[r].data;
			if (i > 0 && rows[r].mix) begin
				rand_bits(3, pick);
				if (pick[2:0] == 3'b111) begin   // about one word in eight.
					we = 1'b1;
					rand_bits(3, v);
					addr = v[3:0];
					rand_bits(16, v);
					data = v[15:0];
				end
			end
			apply_word(names[r], w, we, addr, data);
		end
	endtask

	initial begin
		lfsr     = 32'h4f55;
		rstb     = 1'b1;
		cfg_we   = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		for (int l = 0; l < dsp_pkg::lanes; l++) begin
			codes[l] = '0;
		end
		m_w   = '{0, 0, 0};
		m_thr = 0;
		m_sh  = 0;
		m_h0  = 0;
		m_h1  = 0;
		cyc   = 0;
		for (int s = 0; s < base; s++) begin
			word_tag[s] = "reset";
		end
		#2 rstb = 1'b0;
		repeat (16) @(negedge clk);
		rstb = 1'b1;
		for (int r = 0; r < num_rows; r++) begin
			run_row(r);
		end
		for (int i = 0; i < drain; i++) begin
			apply_word("drain", '0, 1'b0, '0, '0);
		end
		$display("All tests passed");
		$finish;
	end

	initial begin : watchdog
		int limit;
		limit = 18 + 20 * drain;
		for (int r = 0; r < num_rows; r++) begin
			limit += 20 * ((rows[r].n_rand == 0) ? 1 : int'(rows[r].n_rand));
		end
		repeat (limit) @(posedge clk);
		$display("timeout: the test sequence did not finish within %0d cycles", limit);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule : dsp_backend_tb

`default_nettype wire

//--- hw/dsp_backend.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_backend #(
	parameter int hist_depth = 4
) (
	input  logic clk,
	input  logic rstb,

	input  logic signed [dsp_pkg::code_bits-1:0] codes_i [dsp_pkg::lanes-1:0],

	input  logic                              cfg_we_i,
	input  logic [dsp_pkg::cfg_addr_bits-1:0] cfg_addr_i,
	input  dsp_pkg::dsp_cfg_word_u            cfg_data_i,

	output logic signed [dsp_pkg::est_out_bits-1:0] estimated_bits_o [dsp_pkg::lanes-1:0],
	output logic [dsp_pkg::lanes-1:0]               sliced_bits_o,
	output logic [dsp_pkg::lanes-1:0]               checked_bits_o
);

	logic signed [dsp_pkg::code_bits-1:0]     hist       [hist_depth-1:0][dsp_pkg::lanes-1:0];
	logic signed [dsp_pkg::code_bits-1:0]     prev_codes [dsp_pkg::lanes-1:0];
	logic signed [dsp_pkg::code_bits-1:0]     codes_cur  [dsp_pkg::lanes-1:0];
	logic signed [dsp_pkg::code_bits-1:0]     codes_next [dsp_pkg::lanes-1:0];

	logic signed [dsp_pkg::weight_bits-1:0]   weights  [dsp_pkg::ffe_taps-1:0];
	logic signed [dsp_pkg::thresh_bits-1:0]   thresh;
	logic        [dsp_pkg::shift_bits-1:0]    ffe_shift;
	logic signed [dsp_pkg::chan_est_bits-1:0] chan_est [dsp_pkg::chan_taps-1:0];

	// ############################################################
	// code history taps
	assign prev_codes = hist[0];   // word w-1 beside word w at the ffe.
	assign codes_next = hist[1];   // checker sees word w+1 here.
	assign codes_cur  = hist[2];   // and word w here.

	lane_history #(
		.hist_depth (hist_depth)
	) hist_i (
		.clk     (clk),
		.rstb    (rstb),
		.codes_i (codes_i),
		.hist_o  (hist)
	);

	dsp_config_regs cfg_i (
		.clk         (clk),
		.rstb        (rstb),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_data_i  (cfg_data_i),
		.weights_o   (weights),
		.thresh_o    (thresh),
		.ffe_shift_o (ffe_shift),
		.chan_est_o  (chan_est)
	);

	// ############################################################
	// ffe, slicer and sequence check
	ffe_filter ffe_i (
		.clk          (clk),
		.rstb         (rstb),
		.codes_i      (codes_i),
		.prev_codes_i (prev_codes),
		.weights_i    (weights),
		.shift_i      (ffe_shift),
		.estimated_o  (estimated_bits_o)
	);

	slicer slc_i (
		.clk         (clk),
		.rstb        (rstb),
		.estimated_i (estimated_bits_o),
		.thresh_i    (thresh),
		.bits_o      (sliced_bits_o)
	);

	mlsd_checker mlsd_i (
		.clk          (clk),
		.rstb         (rstb),
		.bits_i       (sliced_bits_o),
		.codes_cur_i  (codes_cur),
		.codes_next_i (codes_next),
		.chan_est_i   (chan_est),
		.checked_o    (checked_bits_o)
	);

endmodule : dsp_backend

`default_nettype wire

//--- hw/dsp_config_regs.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_config_regs (
	input  logic clk,
	input  logic rstb,

	input  logic                              cfg_we_i,
	input  logic [dsp_pkg::cfg_addr_bits-1:0] cfg_addr_i,
	input  dsp_pkg::dsp_cfg_word_u            cfg_data_i,

	output logic signed [dsp_pkg::weight_bits-1:0]   weights_o [dsp_pkg::ffe_taps-1:0],
	output logic signed [dsp_pkg::thresh_bits-1:0]   thresh_o,
	output logic        [dsp_pkg::shift_bits-1:0]    ffe_shift_o,
	output logic signed [dsp_pkg::chan_est_bits-1:0] chan_est_o [dsp_pkg::chan_taps-1:0]
);

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int t = 0; t < dsp_pkg::ffe_taps; t++) begin
				weights_o[t] <= '0;
			end
			for (int t = 0; t < dsp_pkg::chan_taps; t++) begin
				chan_est_o[t] <= '0;
			end
			thresh_o    <= '0;
			ffe_shift_o <= '0;
		end else if (cfg_we_i) begin
			case (cfg_addr_i)
				dsp_pkg::addr_w0: begin
					weights_o[0] <= cfg_data_i.coef_view.coef;
				end
				dsp_pkg::addr_w1: begin
					weights_o[1] <= cfg_data_i.coef_view.coef;
				end
				dsp_pkg::addr_w2: begin
					weights_o[2] <= cfg_data_i.coef_view.coef;
				end
				dsp_pkg::addr_ctrl: begin
					thresh_o    <= cfg_data_i.ctrl_view.thresh;
					ffe_shift_o <= cfg_data_i.ctrl_view.ffe_shift;
				end
				dsp_pkg::addr_h0: begin
					chan_est_o[0] <= cfg_data_i.coef_view.coef;   // main cursor.
				end
				dsp_pkg::addr_h1: begin
					chan_est_o[1] <= cfg_data_i.coef_view.coef;   // post cursor.
				end
				default: begin
					// writes to an unmapped address are dropped.
				end
			endcase
		end
	end

endmodule : dsp_config_regs

`default_nettype wire

//--- hw/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	// ############################################################
	// datapath widths
	localparam int lanes         = 4;   // symbols per word.
	localparam int code_bits     = 8;   // signed adc code.
	localparam int weight_bits   = 8;
	localparam int est_out_bits  = 10;
	localparam int shift_bits    = 4;
	localparam int thresh_bits   = 10;
	localparam int chan_est_bits = 8;
	localparam int ffe_taps      = 3;
	localparam int chan_taps     = 2;

	// ############################################################
	// config port and register map
	localparam int cfg_addr_bits = 4;
	localparam int cfg_data_bits = 16;

	localparam logic [cfg_addr_bits-1:0] addr_w0   = 4'd0;
	localparam logic [cfg_addr_bits-1:0] addr_w1   = 4'd1;
	localparam logic [cfg_addr_bits-1:0] addr_w2   = 4'd2;
	localparam logic [cfg_addr_bits-1:0] addr_ctrl = 4'd3;   // threshold and shift.
	localparam logic [cfg_addr_bits-1:0] addr_h0   = 4'd4;
	localparam logic [cfg_addr_bits-1:0] addr_h1   = 4'd5;

	// one data word, read as a coefficient or as the control fields.
	typedef union packed {
		struct packed {
			logic [cfg_data_bits-weight_bits-1:0] pad;
			logic signed [weight_bits-1:0]        coef;   // ffe weight or channel tap.
		} coef_view;
		struct packed {
			logic [shift_bits-1:0]                          ffe_shift;
			logic [cfg_data_bits-shift_bits-thresh_bits-1:0] pad;
			logic signed [thresh_bits-1:0]                  thresh;
		} ctrl_view;
	} dsp_cfg_word_u;

endpackage : dsp_pkg

`default_nettype wire

//--- hw/ffe_filter.sv
`timescale 1ns/1ns
`default_nettype none

module ffe_filter (
	input  logic clk,
	input  logic rstb,

	input  logic signed [dsp_pkg::code_bits-1:0]   codes_i      [dsp_pkg::lanes-1:0],
	input  logic signed [dsp_pkg::code_bits-1:0]   prev_codes_i [dsp_pkg::lanes-1:0],
	input  logic signed [dsp_pkg::weight_bits-1:0] weights_i    [dsp_pkg::ffe_taps-1:0],
	input  logic        [dsp_pkg::shift_bits-1:0]  shift_i,

	output logic signed [dsp_pkg::est_out_bits-1:0] estimated_o [dsp_pkg::lanes-1:0]
);

	localparam int win_len   = dsp_pkg::lanes + dsp_pkg::ffe_taps - 1;
	localparam int prod_bits = dsp_pkg::code_bits + dsp_pkg::weight_bits;
	localparam int sum_bits  = prod_bits + $clog2(dsp_pkg::ffe_taps);

	localparam logic signed [sum_bits-1:0] sat_max = (1 <<< (dsp_pkg::est_out_bits-1)) - 1;
	localparam logic signed [sum_bits-1:0] sat_min = -sat_max;   // symmetric clamp.

	logic signed [dsp_pkg::code_bits-1:0]    window  [win_len-1:0];
	logic signed [sum_bits-1:0]              acc     [dsp_pkg::lanes-1:0];
	logic signed [sum_bits-1:0]              shifted [dsp_pkg::lanes-1:0];
	logic signed [dsp_pkg::est_out_bits-1:0] sat     [dsp_pkg::lanes-1:0];

	// ############################################################
	// symbol window with the tail of the previous word ahead of the current word.
	genvar gi;
	generate
		for (gi = 0; gi < win_len; gi++) begin : g_win
			if (gi < dsp_pkg::ffe_taps - 1) begin : g_prev
				assign window[gi] = prev_codes_i[dsp_pkg::lanes - (dsp_pkg::ffe_taps - 1) + gi];
			end else begin : g_cur
				assign window[gi] = codes_i[gi - (dsp_pkg::ffe_taps - 1)];
			end
		end
	endgenerate

	// ############################################################
	// tap sum, shift, clamp.
	always_comb begin
		for (int l = 0; l < dsp_pkg::lanes; l++) begin
			acc[l] = '0;
			for (int t = 0; t < dsp_pkg::ffe_taps; t++) begin
				// tap t reaches t symbols back.
				acc[l] = acc[l] + weights_i[t] * window[l + dsp_pkg::ffe_taps - 1 - t];
			end
			shifted[l] = acc[l] >>> shift_i;
			if (shifted[l] > sat_max) begin
				sat[l] = sat_max[dsp_pkg::est_out_bits-1:0];
			end else if (shifted[l] < sat_min) begin
				sat[l] = sat_min[dsp_pkg::est_out_bits-1:0];
			end else begin
				sat[l] = shifted[l][dsp_pkg::est_out_bits-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int l = 0; l < dsp_pkg::lanes; l++) begin
				estimated_o[l] <= '0;
			end
		end else begin
			for (int l = 0; l < dsp_pkg::lanes; l++) begin
				estimated_o[l] <= sat[l];
			end
		end
	end

endmodule : ffe_filter

`default_nettype wire

//--- hw/lane_history.sv
`timescale 1ns/1ns
`default_nettype none

module lane_history #(
	parameter int hist_depth = 4
) (
	input  logic clk,
	input  logic rstb,

	input  logic signed [dsp_pkg::code_bits-1:0] codes_i [dsp_pkg::lanes-1:0],

	output logic signed [dsp_pkg::code_bits-1:0] hist_o [hist_depth-1:0][dsp_pkg::lanes-1:0]
);

	// stage k holds the word seen k+1 cycles ago.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int k = 0; k < hist_depth; k++) begin
				for (int l = 0; l < dsp_pkg::lanes; l++) begin
					hist_o[k][l] <= '0;
				end
			end
		end else begin
			for (int l = 0; l < dsp_pkg::lanes; l++) begin
				hist_o[0][l] <= codes_i[l];   // newest word.
			end
			for (int k = 1; k < hist_depth; k++) begin
				for (int l = 0; l < dsp_pkg::lanes; l++) begin
					hist_o[k][l] <= hist_o[k-1][l];
				end
			end
		end
	end

endmodule : lane_history

`default_nettype wire

//--- hw/mlsd_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mlsd_checker (
	input  logic clk,
	input  logic rstb,

	input  logic [dsp_pkg::lanes-1:0] bits_i,   // decisions of word w+1.

	input  logic signed [dsp_pkg::code_bits-1:0]     codes_cur_i  [dsp_pkg::lanes-1:0],
	input  logic signed [dsp_pkg::code_bits-1:0]     codes_next_i [dsp_pkg::lanes-1:0],
	input  logic signed [dsp_pkg::chan_est_bits-1:0] chan_est_i   [dsp_pkg::chan_taps-1:0],

	output logic [dsp_pkg::lanes-1:0] checked_o
);

	localparam int err_bits = dsp_pkg::code_bits + 4;   // sum of two terms up to 3*128 each.

	logic [dsp_pkg::lanes-1:0]   bits_q1;   // word w.
	logic                        last_q2;   // last bit of word w-1.
	logic [dsp_pkg::lanes+1:0]   bit_seq;
	logic signed [dsp_pkg::code_bits-1:0] code_seq [dsp_pkg::lanes:0];
	logic [dsp_pkg::lanes-1:0]   flag;

	// +h for bit 1, -h for bit 0.
	function automatic logic signed [err_bits-1:0] signed_tap(
		input logic signed [dsp_pkg::chan_est_bits-1:0] h,
		input logic                                      b
	);
		logic signed [err_bits-1:0] hx;
		hx = h;
		return b ? hx : -hx;
	endfunction

	function automatic logic signed [err_bits-1:0] abs_val(
		input logic signed [err_bits-1:0] v
	);
		return (v < 0) ? -v : v;
	endfunction

	// distance of both affected codes for candidate d at symbol n.
	function automatic logic signed [err_bits-1:0] err_sum(
		input logic signed [dsp_pkg::code_bits-1:0]     c_cur,
		input logic signed [dsp_pkg::code_bits-1:0]     c_next,
		input logic                                      s_prev,
		input logic                                      d,
		input logic                                      s_next,
		input logic signed [dsp_pkg::chan_est_bits-1:0] h0,
		input logic signed [dsp_pkg::chan_est_bits-1:0] h1
	);
		logic signed [err_bits-1:0] cx;
		logic signed [err_bits-1:0] cnx;
		cx  = c_cur;
		cnx = c_next;
		return abs_val(cx - signed_tap(h0, d) - signed_tap(h1, s_prev))
			+ abs_val(cnx - signed_tap(h0, s_next) - signed_tap(h1, d));
	endfunction

	// bit and code sequences stretched one symbol across each word edge.
	assign bit_seq = {bits_i[0], bits_q1, last_q2};

	always_comb begin
		for (int l = 0; l < dsp_pkg::lanes; l++) begin
			code_seq[l] = codes_cur_i[l];
		end
		code_seq[dsp_pkg::lanes] = codes_next_i[0];
	end

	always_comb begin
		for (int l = 0; l < dsp_pkg::lanes; l++) begin
			flag[l] = err_sum(code_seq[l], code_seq[l+1], bit_seq[l], ~bit_seq[l+1],
					bit_seq[l+2], chan_est_i[0], chan_est_i[1])
				< err_sum(code_seq[l], code_seq[l+1], bit_seq[l], bit_seq[l+1],
					bit_seq[l+2], chan_est_i[0], chan_est_i[1]);
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			bits_q1   <= '0;
			last_q2   <= 1'b0;
			checked_o <= '0;
		end else begin
			bits_q1   <= bits_i;
			last_q2   <= bits_q1[dsp_pkg::lanes-1];
			checked_o <= flag;
		end
	end

endmodule : mlsd_checker

`default_nettype wire

//--- hw/slicer.sv
`timescale 1ns/1ns
`default_nettype none

module slicer (
	input  logic clk,
	input  logic rstb,

	input  logic signed [dsp_pkg::est_out_bits-1:0] estimated_i [dsp_pkg::lanes-1:0],
	input  logic signed [dsp_pkg::thresh_bits-1:0]  thresh_i,

	output logic [dsp_pkg::lanes-1:0] bits_o
);

	logic [dsp_pkg::lanes-1:0] decide;

	always_comb begin
		for (int l = 0; l < dsp_pkg::lanes; l++) begin
			decide[l] = (estimated_i[l] >= thresh_i);   // signed compare.
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			bits_o <= '0;
		end else begin
			bits_o <= decide;
		end
	end

endmodule : slicer

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -Wno-fatal --top-module dsp_backend_tb -f build.f \
	&& ./obj_dir/Vdsp_backend_tb 2>&1)
echo "$out"
echo "$out" | grep -q "^All tests passed$" && echo "PASS" || { echo "FAIL"; exit 1; }
